//--- Bender.yml
package:
  name: replay_top

sources:
  - replay_engine_pkg.sv
  - replay_regs_pkg.sv
  - queue_cfg_if.sv
  - mem_rd_if.sv
  - replay_regs.sv
  - packet_mem.sv
  - replay_queue.sv
  - replay_top.sv
  - target: test
    files:
      - tb_replay_top.sv

//--- mem_rd_if.sv
interface mem_rd_if #(
  parameter int DATA_WIDTH     = replay_engine_pkg::DEFAULT_DATA_WIDTH,
  parameter int MEM_ADDR_WIDTH = replay_engine_pkg::DEFAULT_MEM_ADDR_WIDTH
);

  logic                      rd_req;
  logic [MEM_ADDR_WIDTH-1:0] rd_addr;
  // High in the cycle the request is taken
  logic                      rd_grant;
  // Data and last flag valid one cycle after the grant
  logic [DATA_WIDTH-1:0]     rd_data;
  logic                      rd_last;
  logic                      rd_valid;

  modport queue (
    output rd_req, rd_addr,
    input  rd_grant, rd_data, rd_last, rd_valid
  );

  modport mem (
    input  rd_req, rd_addr,
    output rd_grant, rd_data, rd_last, rd_valid
  );

endinterface

//--- packet_mem.sv
module packet_mem #(
  parameter int DATA_WIDTH     = replay_engine_pkg::DEFAULT_DATA_WIDTH,
  parameter int MEM_ADDR_WIDTH = replay_engine_pkg::DEFAULT_MEM_ADDR_WIDTH,
  parameter int NUM_QUEUES     = replay_engine_pkg::DEFAULT_NUM_QUEUES
) (
  input  logic                      axi_aclk,
  input  logic                      arst_n,
  input  logic                      load_en,
  input  logic [MEM_ADDR_WIDTH-1:0] load_addr,
  input  logic [DATA_WIDTH-1:0]     load_data,
  input  logic                      load_last,
  mem_rd_if.mem                     rd [NUM_QUEUES]
);

  localparam int QW = (NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1;

  // Last flag stored above the data bits
  logic [DATA_WIDTH:0]       mem [2**MEM_ADDR_WIDTH];
  logic [DATA_WIDTH:0]       rd_word;
  logic [NUM_QUEUES-1:0]     req;
  logic [NUM_QUEUES-1:0]     grant;
  logic [NUM_QUEUES-1:0]     valid_q;
  logic [MEM_ADDR_WIDTH-1:0] req_addr [NUM_QUEUES];
  logic [QW-1:0]             rr_ptr;
  logic [QW-1:0]             sel;

  for (genvar q = 0; q < NUM_QUEUES; q++) begin : g_port
    assign req[q]         = rd[q].rd_req;
    assign req_addr[q]    = rd[q].rd_addr;
    assign rd[q].rd_grant = grant[q];
    assign rd[q].rd_valid = valid_q[q];
    // Read data is shared, rd_valid picks the owner
    assign rd[q].rd_data  = rd_word[DATA_WIDTH-1:0];
    assign rd[q].rd_last  = rd_word[DATA_WIDTH];
  end

  // Round-robin search starting at rr_ptr
  always_comb begin
    int idx;
    grant = '0;
    sel   = rr_ptr;
    for (int i = 0; i < NUM_QUEUES; i++) begin
      idx = (int'(rr_ptr) + i) % NUM_QUEUES;
      if (req[idx] && grant == '0) begin
        grant[idx] = 1'b1;
        sel        = QW'(idx);
      end
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (load_en) begin
      mem[load_addr] <= {load_last, load_data};
    end
    if (|req) begin
      rd_word <= mem[req_addr[sel]];
    end
  end

  always_ff @(posedge axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      rr_ptr  <= '0;
      valid_q <= '0;
    end else begin
      valid_q <= grant;
      if (|req) begin
        rr_ptr <= (int'(sel) == NUM_QUEUES - 1) ? '0 : sel + 1'b1;
      end
    end
  end

  a_one_grant: assert property (
    @(posedge axi_aclk) disable iff (!arst_n)
    $onehot0(grant)
  );

endmodule

//--- queue_cfg_if.sv
interface queue_cfg_if #(
  parameter int MEM_ADDR_WIDTH = replay_engine_pkg::DEFAULT_MEM_ADDR_WIDTH
);
  import replay_regs_pkg::*;

  // Shared by all queues
  logic                      sw_rst;
  logic                      start;
  logic                      enable;
  logic [REG_WIDTH-1:0]      replay_count;
  // Window is addr_low up to addr_high minus 1
  logic [MEM_ADDR_WIDTH-1:0] addr_low;
  logic [MEM_ADDR_WIDTH-1:0] addr_high;

  modport regs (
    output sw_rst, start, enable, replay_count, addr_low, addr_high
  );

  modport queue (
    input sw_rst, start, enable, replay_count, addr_low, addr_high
  );

endinterface

//--- replay_engine_pkg.sv
package replay_engine_pkg;

  // Stream word width
  localparam int DEFAULT_DATA_WIDTH = 64;

  // Packet memory depth is 2**DEFAULT_MEM_ADDR_WIDTH words
  localparam int DEFAULT_MEM_ADDR_WIDTH = 8;

  // Output streams built by default
  localparam int DEFAULT_NUM_QUEUES = 4;

endpackage

//--- replay_queue.sv
module replay_queue #(
  parameter int DATA_WIDTH     = replay_engine_pkg::DEFAULT_DATA_WIDTH,
  parameter int MEM_ADDR_WIDTH = replay_engine_pkg::DEFAULT_MEM_ADDR_WIDTH
) (
  input  logic                  axi_aclk,
  input  logic                  arst_n,
  queue_cfg_if.queue            cfg,
  mem_rd_if.queue               rd,
  output logic [DATA_WIDTH-1:0] m_axis_tdata,
  output logic                  m_axis_tvalid,
  output logic                  m_axis_tlast,
  input  logic                  m_axis_tready
);
  import replay_regs_pkg::*;

  logic                      replaying;
  logic                      start_q;
  logic                      start_edge;
  logic [MEM_ADDR_WIDTH-1:0] rd_addr_q;
  logic [MEM_ADDR_WIDTH-1:0] next_addr;
  logic [MEM_ADDR_WIDTH-1:0] win_low;
  logic [MEM_ADDR_WIDTH-1:0] win_high;
  logic [REG_WIDTH-1:0]      passes_left;

  // Two-entry output buffer
  logic [DATA_WIDTH:0] fifo [2];
  logic [1:0]          cnt;
  logic                wr_ptr;
  logic                rd_ptr;
  logic                push;
  logic                pop;

  assign start_edge = cfg.start & ~start_q & cfg.enable & ~replaying & ~cfg.sw_rst;
  assign next_addr  = rd_addr_q + 1'b1;

  // rd_valid marks the one read still in flight
  assign rd.rd_req  = replaying & ~cfg.sw_rst & ((int'(cnt) + int'(rd.rd_valid)) < 2);
  assign rd.rd_addr = rd_addr_q;

  always_ff @(posedge axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      replaying   <= 1'b0;
      start_q     <= 1'b0;
      rd_addr_q   <= '0;
      passes_left <= '0;
    end else begin
      start_q <= cfg.start;
      if (cfg.sw_rst) begin
        replaying <= 1'b0;
      end else if (start_edge) begin
        // Empty window or zero count stays idle
        replaying   <= (cfg.replay_count != '0) && (cfg.addr_high > cfg.addr_low);
        rd_addr_q   <= cfg.addr_low;
        passes_left <= cfg.replay_count;
      end else if (rd.rd_grant) begin
        if (next_addr == win_high) begin
          rd_addr_q   <= win_low;
          passes_left <= passes_left - 1'b1;
          if (passes_left == REG_WIDTH'(1)) begin
            replaying <= 1'b0;
          end
        end else begin
          rd_addr_q <= next_addr;
        end
      end
    end
  end

  // Window held for the whole replay
  always_ff @(posedge axi_aclk) begin
    if (start_edge) begin
      win_low  <= cfg.addr_low;
      win_high <= cfg.addr_high;
    end
  end

  // Reads landing during sw_rst are dropped
  assign push = rd.rd_valid & ~cfg.sw_rst;
  assign pop  = m_axis_tvalid & m_axis_tready;

  always_ff @(posedge axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      cnt    <= '0;
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
    end else if (cfg.sw_rst) begin
      cnt    <= '0;
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
      cnt <= cnt + 2'(push) - 2'(pop);
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (push) begin
      fifo[wr_ptr] <= {rd.rd_last, rd.rd_data};
    end
  end

  assign m_axis_tvalid = cnt != 2'd0;
  assign {m_axis_tlast, m_axis_tdata} = fifo[rd_ptr];

  a_stream_hold: assert property (
    @(posedge axi_aclk) disable iff (!arst_n)
    m_axis_tvalid && !m_axis_tready && !cfg.sw_rst
      |=> m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast)
  );

  // Request throttling keeps a slot free for every read in flight
  a_no_overflow: assert property (
    @(posedge axi_aclk) disable iff (!arst_n)
    rd.rd_valid |-> cnt != 2'd2
  );

endmodule

//--- replay_regs.sv
module replay_regs #(
  parameter int MEM_ADDR_WIDTH = replay_engine_pkg::DEFAULT_MEM_ADDR_WIDTH,
  parameter int NUM_QUEUES     = replay_engine_pkg::DEFAULT_NUM_QUEUES
) (
  input  logic                                      axi_aclk,
  input  logic                                      arst_n,
  input  logic                                      reg_wr_en,
  input  logic                                      reg_rd_en,
  input  logic [replay_regs_pkg::REG_ADDR_WIDTH-1:0] reg_addr,
  input  logic [replay_regs_pkg::REG_WIDTH-1:0]      reg_wdata,
  output logic [replay_regs_pkg::REG_WIDTH-1:0]      reg_rdata,
  output logic                                      reg_rd_valid,
  queue_cfg_if.regs                                 cfg [NUM_QUEUES]
);
  import replay_regs_pkg::*;

  reg_word_u regs [NUM_REGS];
  logic      addr_ok;

  // Indices past the map are write-ignored and read as zero
  assign addr_ok = int'(reg_addr) < NUM_REGS;

  always_ff @(posedge axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_wr_en && addr_ok) begin
      regs[reg_addr] <= reg_wdata;
    end
  end

  always_ff @(posedge axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      reg_rd_valid <= 1'b0;
    end else begin
      reg_rd_valid <= reg_rd_en;
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (reg_rd_en) begin
      reg_rdata <= addr_ok ? REG_WIDTH'(regs[reg_addr]) : '0;
    end
  end

  // Per-queue decode
  for (genvar q = 0; q < NUM_QUEUES; q++) begin : g_cfg
    assign cfg[q].sw_rst = regs[SW_RST_IDX].flag.value;
    assign cfg[q].start  = regs[START_BASE + q].flag.value;
    assign cfg[q].enable = regs[ENABLE_BASE + q].flag.value;
    // Count uses the whole word
    assign cfg[q].replay_count = REG_WIDTH'(regs[COUNT_BASE + q]);
    assign cfg[q].addr_low     = MEM_ADDR_WIDTH'(regs[ADDR_BASE + 2 * q].addr.value);
    assign cfg[q].addr_high    = MEM_ADDR_WIDTH'(regs[ADDR_BASE + 2 * q + 1].addr.value);
  end

  // Host side must not read and write in the same cycle
  a_no_rw_collision: assert property (
    @(posedge axi_aclk) disable iff (!arst_n)
    !(reg_wr_en && reg_rd_en)
  );

endmodule

//--- replay_regs_pkg.sv
package replay_regs_pkg;

  localparam int REG_WIDTH = 32;
  localparam int REG_ADDR_WIDTH = 5;
  localparam int MAX_QUEUES = 4;

  // Map order: reset, starts, counts, windows, enables
  localparam int SW_RST_IDX = 0;
  localparam int START_BASE = SW_RST_IDX + 1;
  localparam int COUNT_BASE = START_BASE + MAX_QUEUES;
  // Low and high window words interleaved per queue
  localparam int ADDR_BASE = COUNT_BASE + MAX_QUEUES;
  localparam int ENABLE_BASE = ADDR_BASE + 2 * MAX_QUEUES;
  localparam int NUM_REGS = ENABLE_BASE + MAX_QUEUES;

  localparam int WIN_WIDTH = replay_engine_pkg::DEFAULT_MEM_ADDR_WIDTH;

  // One register word, seen as a window address or as a single flag
  typedef union packed {
    struct packed {
      logic [REG_WIDTH-WIN_WIDTH-1:0] rsvd;
      logic [WIN_WIDTH-1:0]           value;
    } addr;
    struct packed {
      logic [REG_WIDTH-2:0] rsvd;
      logic                 value;
    } flag;
  } reg_word_u;

endpackage

//--- replay_top.f
replay_engine_pkg.sv
replay_regs_pkg.sv
queue_cfg_if.sv
mem_rd_if.sv
replay_regs.sv
packet_mem.sv
replay_queue.sv
replay_top.sv
tb_replay_top.sv

//--- replay_top.sv
module replay_top #(
  parameter int DATA_WIDTH     = replay_engine_pkg::DEFAULT_DATA_WIDTH,
  parameter int MEM_ADDR_WIDTH = replay_engine_pkg::DEFAULT_MEM_ADDR_WIDTH,
  parameter int NUM_QUEUES     = replay_engine_pkg::DEFAULT_NUM_QUEUES
) (
  input  logic                                      axi_aclk,
  input  logic                                      arst_n,
  input  logic                                      reg_wr_en,
  input  logic                                      reg_rd_en,
  input  logic [replay_regs_pkg::REG_ADDR_WIDTH-1:0] reg_addr,
  input  logic [replay_regs_pkg::REG_WIDTH-1:0]      reg_wdata,
  output logic [replay_regs_pkg::REG_WIDTH-1:0]      reg_rdata,
  output logic                                      reg_rd_valid,
  input  logic                                      load_en,
  input  logic [MEM_ADDR_WIDTH-1:0]                 load_addr,
  input  logic [DATA_WIDTH-1:0]                     load_data,
  input  logic                                      load_last,
  output logic [NUM_QUEUES*DATA_WIDTH-1:0]          m_axis_tdata,
  output logic [NUM_QUEUES-1:0]                     m_axis_tvalid,
  input  logic [NUM_QUEUES-1:0]                     m_axis_tready,
  output logic [NUM_QUEUES-1:0]                     m_axis_tlast
);

  queue_cfg_if #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) cfg [NUM_QUEUES] ();
  mem_rd_if #(.DATA_WIDTH(DATA_WIDTH), .MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) rd [NUM_QUEUES] ();

  replay_regs #(
    .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH),
    .NUM_QUEUES     (NUM_QUEUES)
  ) i_replay_regs (
    .axi_aclk     (axi_aclk),
    .arst_n       (arst_n),
    .reg_wr_en    (reg_wr_en),
    .reg_rd_en    (reg_rd_en),
    .reg_addr     (reg_addr),
    .reg_wdata    (reg_wdata),
    .reg_rdata    (reg_rdata),
    .reg_rd_valid (reg_rd_valid),
    .cfg          (cfg)
  );

  packet_mem #(
    .DATA_WIDTH     (DATA_WIDTH),
    .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH),
    .NUM_QUEUES     (NUM_QUEUES)
  ) i_packet_mem (
    .axi_aclk  (axi_aclk),
    .arst_n    (arst_n),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .load_last (load_last),
    .rd        (rd)
  );

  // One replay engine per output stream
  for (genvar q = 0; q < NUM_QUEUES; q++) begin : g_queue
    replay_queue #(
      .DATA_WIDTH     (DATA_WIDTH),
      .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
    ) i_replay_queue (
      .axi_aclk      (axi_aclk),
      .arst_n        (arst_n),
      .cfg           (cfg[q]),
      .rd            (rd[q]),
      .m_axis_tdata  (m_axis_tdata[q*DATA_WIDTH +: DATA_WIDTH]),
      .m_axis_tvalid (m_axis_tvalid[q]),
      .m_axis_tlast  (m_axis_tlast[q]),
      .m_axis_tready (m_axis_tready[q])
    );
  end

endmodule

//--- tb_replay_top.sv
module tb_replay_top;
  timeunit 1ns;
  timeprecision 1ps;

  import replay_engine_pkg::*;
  import replay_regs_pkg::*;

  localparam int DATA_WIDTH     = DEFAULT_DATA_WIDTH;
  localparam int MEM_ADDR_WIDTH = DEFAULT_MEM_ADDR_WIDTH;
  localparam int NUM_QUEUES     = DEFAULT_NUM_QUEUES;
  localparam int MEM_DEPTH      = 2**MEM_ADDR_WIDTH;
  localparam int ADDR_SPAN      = 2**REG_ADDR_WIDTH;
  localparam int NUM_ROWS       = 10;

  // Stream word with the last flag on top
  typedef logic [DATA_WIDTH:0] word_t;

  typedef struct packed {
    int queue;
    bit enable;
    int count;
    int low;
    int high;
    bit sw_pulse;
    int exp_words;
    bit wait_done;
  } row_t;

  // queue, enable, count, low, high, sw_rst pulse, expected words, wait for drain
  row_t rows [NUM_ROWS] = '{
    '{0, 1, 3, 10, 17, 0, 21, 1},
    // Concurrent group, started together on the last row
    '{0, 1, 2, 40, 45, 0, 10, 0},
    '{1, 1, 3, 60, 68, 0, 24, 0},
    '{2, 1, 1, 100, 120, 0, 20, 0},
    '{3, 1, 4, 250, 253, 0, 12, 1},
    // Disabled, zero count, empty and inverted windows
    '{1, 0, 2, 5, 9, 0, 0, 1},
    '{2, 1, 0, 5, 9, 0, 0, 1},
    '{3, 1, 2, 30, 30, 0, 0, 1},
    '{3, 1, 1, 31, 25, 0, 0, 1},
    '{0, 1, 5, 120, 130, 1, 50, 1}
  };

  logic                             axi_aclk;
  logic                             arst_n;
  logic                             reg_wr_en;
  logic                             reg_rd_en;
  logic [REG_ADDR_WIDTH-1:0]        reg_addr;
  logic [REG_WIDTH-1:0]             reg_wdata;
  logic [REG_WIDTH-1:0]             reg_rdata;
  logic                             reg_rd_valid;
  logic                             load_en;
  logic [MEM_ADDR_WIDTH-1:0]        load_addr;
  logic [DATA_WIDTH-1:0]            load_data;
  logic                             load_last;
  logic [NUM_QUEUES*DATA_WIDTH-1:0] m_axis_tdata;
  logic [NUM_QUEUES-1:0]            m_axis_tvalid;
  logic [NUM_QUEUES-1:0]            m_axis_tready;
  logic [NUM_QUEUES-1:0]            m_axis_tlast;

  logic [DATA_WIDTH-1:0] mem_data [MEM_DEPTH];
  logic                  mem_last [MEM_DEPTH];
  word_t                 exp_q [NUM_QUEUES][$];
  int                    cycle_cnt;
  int                    timeout_limit;

  replay_top #(
    .DATA_WIDTH     (DATA_WIDTH),
    .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH),
    .NUM_QUEUES     (NUM_QUEUES)
  ) i_replay_top (
    .axi_aclk      (axi_aclk),
    .arst_n        (arst_n),
    .reg_wr_en     (reg_wr_en),
    .reg_rd_en     (reg_rd_en),
    .reg_addr      (reg_addr),
    .reg_wdata     (reg_wdata),
    .reg_rdata     (reg_rdata),
    .reg_rd_valid  (reg_rd_valid),
    .load_en       (load_en),
    .load_addr     (load_addr),
    .load_data     (load_data),
    .load_last     (load_last),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tlast  (m_axis_tlast)
  );

  initial begin
    axi_aclk = 1'b0;
    forever #50 axi_aclk = ~axi_aclk;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      report_failure($sformatf("Mismatch at %0t: %s expected %h actual %h",
                               $time, name, exp, act));
    end
  endtask

  task automatic check_reg(input string name, input reg_word_u exp, input reg_word_u act);
    if (act !== exp) begin
      report_failure($sformatf("Mismatch at %0t: %s expected %h actual %h",
                               $time, name, exp, act));
    end
  endtask

  task automatic write_reg(input int idx, input logic [REG_WIDTH-1:0] data);
    @(posedge axi_aclk);
    reg_wr_en <= 1'b1;
    reg_addr  <= REG_ADDR_WIDTH'(idx);
    reg_wdata <= data;
    @(posedge axi_aclk);
    reg_wr_en <= 1'b0;
  endtask

  task automatic read_reg(input int idx, input reg_word_u exp);
    @(posedge axi_aclk);
    reg_rd_en <= 1'b1;
    reg_addr  <= REG_ADDR_WIDTH'(idx);
    @(negedge axi_aclk);
    if (reg_rd_valid) begin
      report_failure("Error: reg_rd_valid was high in the cycle of reg_rd_en");
    end
    @(posedge axi_aclk);
    reg_rd_en <= 1'b0;
    @(negedge axi_aclk);
    if (!reg_rd_valid) begin
      report_failure("Error: reg_rd_valid did not follow reg_rd_en by one cycle");
    end
    check_reg($sformatf("reg_rdata[%0d]", idx), exp, reg_rdata);
  endtask

  // Window low up to high minus 1, repeated count times
  function automatic int build_expected(input row_t r);
    int n;
    n = 0;
    if (r.enable && r.count > 0 && r.high > r.low) begin
      for (int p = 0; p < r.count; p++) begin
        for (int a = r.low; a < r.high; a++) begin
          exp_q[r.queue].push_back({mem_last[a], mem_data[a]});
          n++;
        end
      end
    end
    return n;
  endfunction

  task automatic configure_queue(input row_t r);
    write_reg(COUNT_BASE + r.queue, r.count);
    write_reg(ADDR_BASE + 2 * r.queue, r.low);
    write_reg(ADDR_BASE + 2 * r.queue + 1, r.high);
    write_reg(ENABLE_BASE + r.queue, r.enable);
  endtask

  task automatic start_queues(input logic [NUM_QUEUES-1:0] mask);
    for (int q = 0; q < NUM_QUEUES; q++) begin
      if (mask[q]) write_reg(START_BASE + q, 1);
    end
    for (int q = 0; q < NUM_QUEUES; q++) begin
      if (mask[q]) write_reg(START_BASE + q, 0);
    end
  endtask

  task automatic wait_drained();
    for (int q = 0; q < NUM_QUEUES; q++) begin
      while (exp_q[q].size() != 0) @(posedge axi_aclk);
    end
  endtask

  // Stop halfway, then replay the whole sequence again
  task automatic pulse_sw_rst(input row_t r);
    while (exp_q[r.queue].size() > r.exp_words / 2) @(posedge axi_aclk);
    write_reg(SW_RST_IDX, 1);
    @(posedge axi_aclk);
    exp_q[r.queue].delete();
    @(negedge axi_aclk);
    if (m_axis_tvalid[r.queue]) begin
      report_failure($sformatf("Error: queue %0d tvalid still high after sw_rst", r.queue));
    end
    repeat (10) @(posedge axi_aclk);
    write_reg(SW_RST_IDX, 0);
    void'(build_expected(r));
    start_queues(NUM_QUEUES'(1) << r.queue);
  endtask

  // Roughly 70 percent ready per queue
  always @(posedge axi_aclk) begin
    for (int q = 0; q < NUM_QUEUES; q++) begin
      m_axis_tready[q] <= ($urandom % 100) < 70;
    end
  end

  // Transfer happens at the next rising edge when both are high here
  always @(negedge axi_aclk) begin
    word_t got;
    if (arst_n) begin
      for (int q = 0; q < NUM_QUEUES; q++) begin
        if (m_axis_tvalid[q] && exp_q[q].size() == 0) begin
          report_failure($sformatf("Error: queue %0d raised tvalid with no word expected", q));
        end else if (m_axis_tvalid[q] && m_axis_tready[q]) begin
          got = {m_axis_tlast[q], m_axis_tdata[q*DATA_WIDTH +: DATA_WIDTH]};
          check_word($sformatf("m_axis_tlast/tdata[%0d]", q), exp_q[q].pop_front(), got);
        end
      end
    end
  end

  always @(posedge axi_aclk) begin
    cycle_cnt++;
    if (timeout_limit > 0 && cycle_cnt > timeout_limit) begin
      report_failure($sformatf("Error: run did not finish within %0d cycles", timeout_limit));
    end
  end

  initial begin
    int                    total;
    int                    n;
    reg_word_u             shadow [ADDR_SPAN];
    logic [REG_WIDTH-1:0]  word;
    logic [NUM_QUEUES-1:0] pending;
    void'($urandom(32'hcf22_6553));
    arst_n        = 1'b0;
    reg_wr_en     = 1'b0;
    reg_rd_en     = 1'b0;
    reg_addr      = '0;
    reg_wdata     = '0;
    load_en       = 1'b0;
    load_addr     = '0;
    load_data     = '0;
    load_last     = 1'b0;
    m_axis_tready = '0;
    cycle_cnt     = 0;

    // Four cycles per word covers a sink that is ready only 30 percent of the time
    total = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      total += (rows[r].sw_pulse ? 2 : 1) * rows[r].exp_words;
    end
    timeout_limit = 200 + 4 * total + MEM_DEPTH + 6 * ADDR_SPAN + 60 * NUM_ROWS;

    for (int a = 0; a < MEM_DEPTH; a++) begin
      mem_data[a] = {$urandom, $urandom};
      mem_last[a] = ($urandom % 4) == 0;
    end

    repeat (10) @(posedge axi_aclk);
    arst_n <= 1'b1;

    for (int a = 0; a < MEM_DEPTH; a++) begin
      @(posedge axi_aclk);
      load_en   <= 1'b1;
      load_addr <= MEM_ADDR_WIDTH'(a);
      load_data <= mem_data[a];
      load_last <= mem_last[a];
    end
    @(posedge axi_aclk);
    load_en <= 1'b0;

    // Register map, including indices past the end
    for (int i = 0; i < ADDR_SPAN; i++) begin
      word = $urandom;
      write_reg(i, word);
      shadow[i] = (i < NUM_REGS) ? word : '0;
    end
    for (int i = 0; i < ADDR_SPAN; i++) begin
      read_reg(i, shadow[i]);
    end
    for (int i = 0; i < NUM_REGS; i++) begin
      write_reg(i, 0);
    end

    pending = '0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      configure_queue(rows[r]);
      n = build_expected(rows[r]);
      if (n != rows[r].exp_words) begin
        report_failure($sformatf("Error: row %0d lists %0d words but its window gives %0d",
                                 r, rows[r].exp_words, n));
      end
      pending[rows[r].queue] = 1'b1;
      if (rows[r].wait_done) begin
        start_queues(pending);
        pending = '0;
        if (rows[r].sw_pulse) pulse_sw_rst(rows[r]);
        wait_drained();
        repeat (20) @(posedge axi_aclk);
      end
    end

    $display("All checks passed");
    $finish;
  end

endmodule
